// ==== Bender.yml ====
package:
  name: spi_master_ctrl

sources:
  - include_dirs:
      - hw
    files:
      - hw/spi_link_pkg.sv
      - hw/spi_host_pkg.sv
      - hw/spi_host_port.sv
      - hw/spi_clk_divider.sv
      - hw/spi_master_core.sv
      - hw/spi_controller_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/spi_asserts.sv
      - bench/spi_slave_model.sv
      - bench/spi_tb.sv

// ==== bench/spi_asserts.sv ====
`default_nettype none

module spi_asserts
(
    input  logic wr,
    input  logic res_senderr,
    input  logic req,
    input  logic ack,
    input  logic sck,
    input  logic mosi,
    input  logic ss
);

    timeunit 1ns;
    timeprecision 100ps;

    ////////////////////////////////////////
    // Host handshake
    ////////////////////////////////////////

    ack_rise: assert property (@(posedge wr) disable iff (res_senderr)
        $rose(ack) |-> $past(req))
        else $error("ack rose with no request pending");

    ack_fall: assert property (@(posedge wr) disable iff (res_senderr)
        $fell(ack) |-> !$past(req))
        else $error("ack fell while req was still high");

    ////////////////////////////////////////
    // Serial pins while deselected
    ////////////////////////////////////////

    mosi_idle: assert property (@(posedge wr) disable iff (res_senderr)
        ss |-> mosi)
        else $error("mosi low while ss is high");

    sck_idle: assert property (@(posedge wr) disable iff (res_senderr)
        (ss && $past(ss)) |-> $stable(sck))
        else $error("sck moved while ss is high");

endmodule

bind spi_controller_top spi_asserts u_asserts (
    .wr          (wr),
    .res_senderr (res_senderr),
    .req         (req),
    .ack         (ack),
    .sck         (sck),
    .mosi        (mosi),
    .ss          (ss)
);

`default_nettype wire

// ==== bench/spi_slave_model.sv ====
`default_nettype none

`include "spi_macros.svh"

module spi_slave_model
    import spi_link_pkg::*;
(
    input  logic      wr,
    input  logic      sck,
    input  logic      mosi,
    input  logic      ss,
    input  spi_mode_t mode,
    input  logic      lsb_first,
    input  spi_word_t reply,
    output logic      miso,
    output int        cap_cnt
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int W = `SPI_WORD_LEN;

    spi_word_t cap_mem [0:255];                  // Every word seen on mosi, in order.
    spi_word_t rx_sr;
    int        rx_cnt;
    int        tx_cnt;
    logic      sck_q;
    logic      ss_q;
    logic      miso_nxt;

    // Bit number idx of a word in wire order.
    function automatic logic wire_bit(input spi_word_t w, input int idx, input logic lsb);
        return lsb ? w[idx] : w[W-1-idx];
    endfunction

    initial
    begin
        miso     = 1'b1;
        miso_nxt = 1'b1;
        cap_cnt  = 0;
        rx_cnt   = 0;
        tx_cnt   = 0;
        sck_q    = 1'b0;
        ss_q     = 1'b1;
    end

    // Pins are looked at between clock edges, where the DUT outputs have settled.
    always @(negedge wr)
    begin
        if (ss)
        begin
            rx_cnt = 0;
            tx_cnt = 0;
        end
        else if (ss_q)
        begin
            // A fresh select also swallows the sck step of a polarity change.
            if (!mode.cpha)
            begin
                miso_nxt = wire_bit(reply, 0, lsb_first);
                tx_cnt   = 1;
            end
        end
        else if (sck !== sck_q)
        begin
            if ((sck != mode.cpol) ^ mode.cpha)
            begin
                rx_sr[lsb_first ? rx_cnt : W-1-rx_cnt] = mosi;
                rx_cnt++;
                if (rx_cnt == W)
                begin
                    cap_mem[cap_cnt] = rx_sr;
                    cap_cnt++;
                    rx_cnt = 0;
                end
            end
            else
            begin
                if (tx_cnt == W)
                    tx_cnt = 0;                  // Next word follows with ss held low.
                miso_nxt = wire_bit(reply, tx_cnt, lsb_first);
                tx_cnt++;
            end
        end
        sck_q = sck;
        ss_q  = ss;
    end

    always @(posedge wr)
        miso <= miso_nxt;

endmodule

`default_nettype wire

// ==== bench/spi_tb.sv ====
`default_nettype none

`include "spi_macros.svh"

module spi_tb
    import spi_link_pkg::*;
    import spi_host_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_WORDS   = 20;
    localparam int MAX_HALF    = 2 ** (2 ** `SPI_PRESC_BITS);
    localparam int WDOG_CYCLES = NUM_WORDS * 16 * MAX_HALF + 5000;

    logic      wr = 1'b0;
    logic      res_senderr;
    logic      req;
    host_cmd_t cmd;
    logic      miso;
    logic      ack;
    host_rsp_t rsp;
    logic      sck;
    logic      mosi;
    logic      ss;
    spi_mode_t slave_mode;
    logic      slave_lsb;
    spi_word_t slave_reply;
    int        slave_cnt;
    int        errors;
    int        checks;
    int        ss_rises = 0;

    always #5 wr = !wr;

    always @(posedge ss)
        ss_rises++;

    spi_controller_top DUT (
        .wr          (wr),
        .res_senderr (res_senderr),
        .req         (req),
        .cmd         (cmd),
        .miso        (miso),
        .ack         (ack),
        .rsp         (rsp),
        .sck         (sck),
        .mosi        (mosi),
        .ss          (ss)
    );

    spi_slave_model u_slave (
        .wr        (wr),
        .sck       (sck),
        .mosi      (mosi),
        .ss        (ss),
        .mode      (slave_mode),
        .lsb_first (slave_lsb),
        .reply     (slave_reply),
        .miso      (miso),
        .cap_cnt   (slave_cnt)
    );

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic check_word(input string name, input spi_word_t exp, input spi_word_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_rsp(input string name, input host_rsp_t exp, input host_rsp_t act,
                               input bit with_data);
        logic bad;
        bad = ({act.rx_valid, act.tx_empty, act.overrun_err} !==
               {exp.rx_valid, exp.tx_empty, exp.overrun_err});
        if (with_data && act.data !== exp.data)
            bad = 1'b1;
        checks++;
        if (bad)
        begin
            errors++;
            $display("** Error %s: expected data=%h rx_valid=%b tx_empty=%b overrun_err=%b, %s",
                     name, exp.data, exp.rx_valid, exp.tx_empty, exp.overrun_err,
                     $sformatf("actual data=%h rx_valid=%b tx_empty=%b overrun_err=%b",
                               act.data, act.rx_valid, act.tx_empty, act.overrun_err));
        end
    endtask

    task automatic expect_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("** Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic count_equal(input string name, input int exp, input int act);
        checks++;
        if (act != exp)
        begin
            errors++;
            $display("** Error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    ////////////////////////////////////////
    // Host port driver
    ////////////////////////////////////////

    function automatic spi_cfg_t make_cfg(input int presc, input int mode, input logic lsb,
                                          input logic clr);
        spi_cfg_t c;
        c           = '0;
        c.presc     = presc[`SPI_PRESC_BITS-1:0];
        c.mode.cpol = mode[1];                   // Mode number is {cpol, cpha}.
        c.mode.cpha = mode[0];
        c.lsb_first = lsb;
        c.clear_err = clr;
        return c;
    endfunction

    function automatic host_rsp_t make_rsp(input spi_word_t d, input logic v, input logic e,
                                           input logic o);
        host_rsp_t r;
        r.data        = d;
        r.rx_valid    = v;
        r.tx_empty    = e;
        r.overrun_err = o;
        return r;
    endfunction

    task automatic send_cmd(input host_op_t op, input host_payload_u pl, output host_rsp_t r);
        host_cmd_t c;
        c.op      = op;
        c.payload = pl;
        @(posedge wr);
        cmd <= c;
        req <= 1'b1;
        do @(negedge wr); while (ack !== 1'b1);
        r = rsp;
        @(posedge wr);
        req <= 1'b0;
        do @(negedge wr); while (ack !== 1'b0);
    endtask

    task automatic write_cfg(input spi_cfg_t c, output host_rsp_t r);
        host_payload_u pl;
        pl.cfg = c;
        send_cmd(op_write_cfg, pl, r);
    endtask

    task automatic write_data(input spi_word_t w, output host_rsp_t r);
        host_payload_u pl;
        pl.word = w;
        send_cmd(op_write_data, pl, r);
    endtask

    task automatic read_reg(input host_op_t op, output host_rsp_t r);
        host_payload_u pl;
        pl.word = '0;
        send_cmd(op, pl, r);
    endtask

    task automatic wait_idle();
        do @(negedge wr); while (ss !== 1'b1);
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic after_reset();
        host_rsp_t r;
        @(negedge wr);
        expect_bit("reset ss", 1'b1, ss);
        expect_bit("reset mosi", 1'b1, mosi);
        read_reg(op_read_status, r);
        compare_rsp("reset status", make_rsp('0, 1'b0, 1'b1, 1'b0), r, 1'b0);
    endtask

    task automatic exchange(input string name, input spi_cfg_t c);
        host_rsp_t r;
        spi_word_t tx;
        spi_word_t rx;
        int        base;
        tx          = $urandom_range(255);
        rx          = $urandom_range(255);
        slave_mode  = c.mode;
        slave_lsb   = c.lsb_first;
        slave_reply = rx;
        base        = slave_cnt;
        write_cfg(c, r);
        write_data(tx, r);
        wait_idle();
        count_equal({name, " words"}, base + 1, slave_cnt);
        check_word({name, " mosi"}, tx, u_slave.cap_mem[base]);
        read_reg(op_read_status, r);
        compare_rsp({name, " status before"}, make_rsp(rx, 1'b1, 1'b1, 1'b0), r, 1'b1);
        read_reg(op_read_data, r);
        compare_rsp({name, " read"}, make_rsp(rx, 1'b1, 1'b1, 1'b0), r, 1'b1);
        read_reg(op_read_status, r);
        compare_rsp({name, " status after"}, make_rsp(rx, 1'b0, 1'b1, 1'b0), r, 1'b1);
    endtask

    task automatic half_period(input int presc);
        host_rsp_t r;
        logic      s0;
        int        n;
        slave_mode = '0;
        slave_lsb  = 1'b0;
        write_cfg(make_cfg(presc, 0, 1'b0, 1'b0), r);
        write_data($urandom_range(255), r);
        s0 = sck;
        do @(negedge wr); while (sck === s0);
        s0 = sck;
        n  = 0;
        do
        begin
            @(negedge wr);
            n++;
        end
        while (sck === s0);
        count_equal($sformatf("half period presc %0d", presc), 2 ** (presc + 1), n);
        wait_idle();
        read_reg(op_read_data, r);
    endtask

    task automatic overrun();
        host_rsp_t r;
        spi_word_t w [4];
        int        base;
        for (int i = 0; i < 4; i++)
            w[i] = $urandom_range(255);
        slave_mode = '0;
        slave_lsb  = 1'b0;
        base       = slave_cnt;
        write_cfg(make_cfg(3, 0, 1'b0, 1'b0), r);
        write_data(w[0], r);
        write_data(w[1], r);                     // Waits in the buffer.
        write_data(w[2], r);
        compare_rsp("overrun third write", make_rsp('0, 1'b0, 1'b0, 1'b0), r, 1'b0);
        write_data(w[3], r);
        read_reg(op_read_status, r);
        compare_rsp("overrun flag set", make_rsp('0, 1'b0, 1'b0, 1'b1), r, 1'b0);
        wait_idle();
        count_equal("overrun words", base + 2, slave_cnt);
        check_word("overrun first", w[0], u_slave.cap_mem[base]);
        check_word("overrun second", w[1], u_slave.cap_mem[base + 1]);
        write_cfg(make_cfg(3, 0, 1'b0, 1'b1), r);
        read_reg(op_read_status, r);
        compare_rsp("overrun cleared", make_rsp('0, 1'b1, 1'b1, 1'b0), r, 1'b0);
        read_reg(op_read_data, r);
    endtask

    task automatic ss_between_words(input bit late);
        host_rsp_t r;
        spi_word_t w0;
        spi_word_t w1;
        int        base;
        int        rises;
        w0         = $urandom_range(255);
        w1         = $urandom_range(255);
        slave_mode = 2'b01;
        slave_lsb  = 1'b0;
        write_cfg(make_cfg(2, 1, 1'b0, 1'b0), r);
        base  = slave_cnt;
        rises = ss_rises;
        write_data(w0, r);
        if (late)
            wait_idle();
        write_data(w1, r);
        wait_idle();
        count_equal(late ? "ss rises late" : "ss rises early", late ? 2 : 1, ss_rises - rises);
        check_word("ss gap first", w0, u_slave.cap_mem[base]);
        check_word("ss gap second", w1, u_slave.cap_mem[base + 1]);
        read_reg(op_read_data, r);
    endtask

    ////////////////////////////////////////
    // Run control
    ////////////////////////////////////////

    initial
    begin
        void'($urandom(32'h06b3_8ff7));
        errors      = 0;
        checks      = 0;
        res_senderr = 1'b1;
        req         = 1'b0;
        cmd         = '0;
        slave_mode  = '0;
        slave_lsb   = 1'b0;
        slave_reply = '0;
        repeat (16) @(posedge wr);
        res_senderr <= 1'b0;
        repeat (2) @(posedge wr);
        after_reset();
        for (int m = 0; m < 4; m++)
            exchange($sformatf("mode %0d msb", m), make_cfg(1, m, 1'b0, 1'b0));
        for (int m = 0; m < 4; m++)
            exchange($sformatf("mode %0d lsb", m), make_cfg(0, m, 1'b1, 1'b0));
        half_period(0);
        half_period(2);
        half_period(4);
        overrun();
        ss_between_words(1'b0);
        ss_between_words(1'b1);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    initial
    begin
        repeat (WDOG_CYCLES) @(posedge wr);
        $display("Watchdog expired: the tests did not finish within %0d cycles", WDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+hw
hw/spi_link_pkg.sv
hw/spi_host_pkg.sv
hw/spi_host_port.sv
hw/spi_clk_divider.sv
hw/spi_master_core.sv
hw/spi_controller_top.sv
bench/spi_asserts.sv
bench/spi_slave_model.sv
bench/spi_tb.sv

// ==== hw/spi_clk_divider.sv ====
`default_nettype none

`include "spi_macros.svh"

module spi_clk_divider
(
    input  logic                       wr,
    input  logic                       res_senderr,
    input  logic                       run,
    input  logic [`SPI_PRESC_BITS-1:0] presc,
    output logic                       tick
);

    logic [`SPI_CNT_BITS-1:0] cnt;
    logic [`SPI_CNT_BITS-1:0] limit;

    // Mask of presc+1 ones, so the count runs through 2**(presc+1) values.
    assign limit = {`SPI_CNT_BITS{1'b1}} >> (`SPI_CNT_BITS - 1 - presc);

    assign tick = run && (cnt == limit);

    always_ff @(posedge wr or posedge res_senderr)
    begin
        if (res_senderr)
        begin
            cnt <= '0;
        end
        else
        begin
            if (!run)
                cnt <= '0;
            else if (cnt == limit)
                cnt <= '0;
            else
                cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/spi_controller_top.sv ====
`default_nettype none

`include "spi_macros.svh"

module spi_controller_top
    import spi_link_pkg::*;
    import spi_host_pkg::*;
(
    input  logic      wr,
    input  logic      res_senderr,
    input  logic      req,
    input  host_cmd_t cmd,
    input  logic      miso,
    output logic      ack,
    output host_rsp_t rsp,
    output logic      sck,
    output logic      mosi,
    output logic      ss
);

    spi_word_t                  tx_word;
    logic                       tx_full;
    spi_cfg_t                   cfg;
    logic                       tx_take;
    spi_word_t                  rx_word;
    logic                       rx_done;
    logic                       run;
    logic [`SPI_PRESC_BITS-1:0] presc;
    logic                       tick;

    spi_host_port u_host_port (
        .wr          (wr),
        .res_senderr (res_senderr),
        .req         (req),
        .cmd         (cmd),
        .tx_take     (tx_take),
        .rx_word     (rx_word),
        .rx_done     (rx_done),
        .ack         (ack),
        .rsp         (rsp),
        .tx_word     (tx_word),
        .tx_full     (tx_full),
        .cfg         (cfg)
    );

    spi_clk_divider u_clk_divider (
        .wr          (wr),
        .res_senderr (res_senderr),
        .run         (run),
        .presc       (presc),
        .tick        (tick)
    );

    spi_master_core u_master_core (
        .wr          (wr),
        .res_senderr (res_senderr),
        .tx_word     (tx_word),
        .tx_full     (tx_full),
        .cfg         (cfg),
        .tick        (tick),
        .miso        (miso),
        .tx_take     (tx_take),
        .rx_word     (rx_word),
        .rx_done     (rx_done),
        .run         (run),
        .presc       (presc),
        .sck         (sck),
        .mosi        (mosi),
        .ss          (ss)
    );

endmodule

`default_nettype wire

// ==== hw/spi_host_pkg.sv ====
`default_nettype none

package spi_host_pkg;

    import spi_link_pkg::*;

    ////////////////////////////////////////
    // Host command port types
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        op_write_cfg   = 2'd0,
        op_write_data  = 2'd1,
        op_read_data   = 2'd2,
        op_read_status = 2'd3
    } host_op_t;

    // One payload word, read as configuration or as data by opcode.
    typedef union packed {
        spi_cfg_t  cfg;
        spi_word_t word;
    } host_payload_u;

    typedef struct packed {
        host_op_t      op;
        host_payload_u payload;
    } host_cmd_t;

    typedef struct packed {
        spi_word_t data;                         // Receive register contents.
        logic      rx_valid;
        logic      tx_empty;
        logic      overrun_err;                  // Sticky until cleared by a config write.
    } host_rsp_t;

endpackage

`default_nettype wire

// ==== hw/spi_host_port.sv ====
`default_nettype none

module spi_host_port
    import spi_link_pkg::*;
    import spi_host_pkg::*;
(
    input  logic      wr,
    input  logic      res_senderr,
    input  logic      req,
    input  host_cmd_t cmd,
    input  logic      tx_take,
    input  spi_word_t rx_word,
    input  logic      rx_done,
    output logic      ack,
    output host_rsp_t rsp,
    output spi_word_t tx_word,
    output logic      tx_full,
    output spi_cfg_t  cfg
);

    logic      accept;
    logic      wr_cfg;
    logic      wr_data;
    logic      rd_data;
    logic      rx_valid;
    logic      overrun_err;
    spi_word_t rx_data;
    spi_cfg_t  cfg_in;

    ////////////////////////////////////////
    // Command decode
    ////////////////////////////////////////

    assign accept = req && !ack;                 // One action per request.

    always_comb
    begin
        wr_cfg  = 1'b0;
        wr_data = 1'b0;
        rd_data = 1'b0;
        if (accept)
        begin
            case (cmd.op)
                op_write_cfg:   wr_cfg  = 1'b1;
                op_write_data:  wr_data = 1'b1;
                op_read_data:   rd_data = 1'b1;
                op_read_status: ;
                default: ;
            endcase
        end
    end

    always_comb
    begin
        cfg_in           = cmd.payload.cfg;
        cfg_in.clear_err = 1'b0;                 // The clear bit acts once and is not kept.
    end

    ////////////////////////////////////////
    // Handshake, buffers and flags
    ////////////////////////////////////////

    always_ff @(posedge wr or posedge res_senderr)
    begin
        if (res_senderr)
        begin
            ack         <= 1'b0;
            tx_full     <= 1'b0;
            rx_valid    <= 1'b0;
            overrun_err <= 1'b0;
            cfg         <= '0;
        end
        else
        begin
            if (accept)
                ack <= 1'b1;
            else if (ack && !req)
                ack <= 1'b0;

            if (wr_data && !tx_full)
                tx_full <= 1'b1;
            else if (tx_take)
                tx_full <= 1'b0;

            if (wr_data && tx_full)
                overrun_err <= 1'b1;             // Word is dropped.
            else if (wr_cfg && cmd.payload.cfg.clear_err)
                overrun_err <= 1'b0;

            if (wr_cfg)
                cfg <= cfg_in;

            if (rx_done)
                rx_valid <= 1'b1;                // A new word wins over a read in the same cycle.
            else if (rd_data)
                rx_valid <= 1'b0;
        end
    end

    always_ff @(posedge wr)
    begin
        if (wr_data && !tx_full)
            tx_word <= cmd.payload.word;
        if (rx_done)
            rx_data <= rx_word;
        if (accept)
        begin
            rsp.data        <= rx_data;          // Flags are taken before the command acts.
            rsp.rx_valid    <= rx_valid;
            rsp.tx_empty    <= !tx_full;
            rsp.overrun_err <= overrun_err;
        end
    end

endmodule

`default_nettype wire

// ==== hw/spi_link_pkg.sv ====
`default_nettype none

`include "spi_macros.svh"

package spi_link_pkg;

    ////////////////////////////////////////
    // Serial side types
    ////////////////////////////////////////

    typedef logic [`SPI_WORD_LEN-1:0] spi_word_t;

    typedef struct packed {
        logic cpol;                              // Idle level of sck.
        logic cpha;                              // Sample on the trailing edge when set.
    } spi_mode_t;

    typedef struct packed {
        logic [`SPI_PRESC_BITS-1:0] presc;       // Half period is 2**(presc+1) cycles.
        spi_mode_t                  mode;
        logic                       lsb_first;
        logic                       clear_err;   // Only meaningful on the host write.
        logic                       spare;
    } spi_cfg_t;

endpackage

`default_nettype wire

// ==== hw/spi_macros.svh ====
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

// Bits shifted per transfer.
`define SPI_WORD_LEN 8

// The prescaler selects a half period of 2**(presc+1) clock cycles.
`define SPI_PRESC_BITS 3

// The divider counter has to reach 2**(2**SPI_PRESC_BITS) - 1.
`define SPI_CNT_BITS 8

`endif

// ==== hw/spi_master_core.sv ====
`default_nettype none

`include "spi_macros.svh"

module spi_master_core
    import spi_link_pkg::*;
(
    input  logic                       wr,
    input  logic                       res_senderr,
    input  spi_word_t                  tx_word,
    input  logic                       tx_full,
    input  spi_cfg_t                   cfg,
    input  logic                       tick,
    input  logic                       miso,
    output logic                       tx_take,
    output spi_word_t                  rx_word,
    output logic                       rx_done,
    output logic                       run,
    output logic [`SPI_PRESC_BITS-1:0] presc,
    output logic                       sck,
    output logic                       mosi,
    output logic                       ss
);

    localparam int W         = `SPI_WORD_LEN;
    localparam int EDGE_BITS = $clog2(2 * W);
    localparam logic [EDGE_BITS-1:0] LAST_EDGE = EDGE_BITS'(2 * W - 1);

    function automatic spi_word_t flip_bits(input spi_word_t w);
        spi_word_t r;
        for (int i = 0; i < W; i++)
            r[i] = w[W-1-i];
        return r;
    endfunction

    logic                       busy;
    logic                       last_q;
    logic [EDGE_BITS-1:0]       edge_idx;
    logic                       sck_int;
    logic                       mosi_q;
    spi_mode_t                  mode_q;
    logic                       lsb_q;
    logic [`SPI_PRESC_BITS-1:0] presc_q;
    spi_word_t                  shift_out;
    spi_word_t                  shift_in;
    spi_word_t                  load_word;
    logic                       start;
    logic                       step;
    logic                       sample_en;
    logic                       shift_en;
    logic                       finish;

    ////////////////////////////////////////
    // Strobes
    ////////////////////////////////////////

    assign start     = !busy && tx_full;
    assign step      = busy && !last_q && tick;
    assign sample_en = step && (edge_idx[0] == mode_q.cpha);
    assign shift_en  = step && (edge_idx[0] != mode_q.cpha);
    assign finish    = busy && last_q;              // Cycle after the last sck edge.

    // Words always leave MSB first, so LSB-first data is reversed on load.
    assign load_word = cfg.lsb_first ? flip_bits(tx_word) : tx_word;

    assign tx_take = start;
    assign rx_done = finish;
    assign rx_word = lsb_q ? flip_bits(shift_in) : shift_in;

    assign run   = busy;
    assign presc = presc_q;
    assign sck   = sck_int ^ mode_q.cpol;
    assign mosi  = ss ? 1'b1 : mosi_q;

    ////////////////////////////////////////
    // Transfer control
    ////////////////////////////////////////

    always_ff @(posedge wr or posedge res_senderr)
    begin
        if (res_senderr)
        begin
            busy     <= 1'b0;
            last_q   <= 1'b0;
            edge_idx <= '0;
            sck_int  <= 1'b0;
            mosi_q   <= 1'b1;
            ss       <= 1'b1;
            mode_q   <= '0;
            lsb_q    <= 1'b0;
            presc_q  <= '0;
        end
        else
        begin
            if (start)
            begin
                busy     <= 1'b1;
                ss       <= 1'b0;
                mode_q   <= cfg.mode;
                lsb_q    <= cfg.lsb_first;
                presc_q  <= cfg.presc;
                edge_idx <= '0;
                mosi_q   <= load_word[W-1];      // First bit is set up before any edge.
            end

            if (step)
            begin
                sck_int  <= !sck_int;
                edge_idx <= edge_idx + 1'b1;
                if (edge_idx == LAST_EDGE)
                    last_q <= 1'b1;
            end

            if (shift_en)
                mosi_q <= shift_out[W-1];

            if (finish)
            begin
                busy   <= 1'b0;
                last_q <= 1'b0;
                ss     <= !tx_full;              // Keep the slave selected for a waiting word.
            end
        end
    end

    ////////////////////////////////////////
    // Shift registers
    ////////////////////////////////////////

    always_ff @(posedge wr)
    begin
        if (start)
        begin
            if (cfg.mode.cpha)
                shift_out <= load_word;
            else
                shift_out <= {load_word[W-2:0], 1'b1};
        end
        else if (shift_en)
        begin
            shift_out <= {shift_out[W-2:0], 1'b1};
        end

        if (sample_en)
            shift_in <= {shift_in[W-2:0], miso};
    end

endmodule

`default_nettype wire
